/* filelist.f */
+incdir+include
source/geom_pkg.sv
source/triangle_fifo.sv
source/world_camera_transformer.sv
source/perspective_projector.sv
source/geometry_front.sv
test/geometry_front_props.sv
test/tb_geometry_front.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the geometry front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f filelist.f --top-module tb_geometry_front -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_geometry_front +verilator+error+limit+1000)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qxF '*** PASSED ***'; then
    exit 0
fi
echo "Simulation did not report success"
exit 1

/* test/tb_geometry_front.sv */
`timescale 1ns/1ps
`include "geom_macros.svh"

module tb_geometry_front
    import geom_pkg::*;
();

    localparam int LIMIT = 20000;   // Cycles any single wait may take
    localparam int STALL = 1000;    // Longer than one projector pass
    localparam int FRAC  = `GEOM_FRAC_BITS;

    logic             clk;
    logic             rst;
    transform_t       transform;
    triangle_t        in_triangle;
    logic             in_valid;
    logic             in_ready;
    logic             busy;
    screen_triangle_t out_triangle;
    logic             out_valid;
    logic             out_ready;
    logic [15:0]      cull_count;

    screen_triangle_t exp_q[$];     // Expected screen triangles in arrival order
    screen_triangle_t head;
    integer           seed;
    int               cpos[3];      // Pose in whole units with index 0 for x
    int               sn[3];
    int               cs[3];
    int               error_count;
    int               mark;
    int               pass_tests;
    int               fail_tests;
    logic             aborted;

    geometry_front dut_i (
        .clk          (clk),
        .rst          (rst),
        .transform    (transform),
        .in_triangle  (in_triangle),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .busy         (busy),
        .out_triangle (out_triangle),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .cull_count   (cull_count)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    function automatic q16_16_t to_q(input int v);
        return q16_16_t'(v * (1 << FRAC));
    endfunction

    function automatic int rand_range(input int lo, input int hi);
        int r;
        r = $random(seed) & 32'h7fffffff;
        return lo + r % (hi - lo + 1);
    endfunction

    function automatic vertex_t random_vertex();
        vertex_t v;
        v.pos.x = to_q(rand_range(-64, 64));
        v.pos.y = to_q(rand_range(-64, 64));
        v.pos.z = to_q(rand_range(1, 64));   // Ahead of a camera that sits at z <= 0
        v.color = color_t'($random(seed));
        return v;
    endfunction

    function automatic triangle_t random_triangle();
        triangle_t t;
        t.v0 = random_vertex();
        t.v1 = random_vertex();
        t.v2 = random_vertex();
        return t;
    endfunction

    // Undoing Rz, then Ry, then Rx gives R^T for R = Rz*Ry*Rx
    function automatic screen_vertex_t expect_vertex(input vertex_t v, output logic culled);
        screen_vertex_t sv;
        longint x;
        longint y;
        longint z;
        longint t;
        x = longint'(v.pos.x >>> FRAC) - cpos[0];
        y = longint'(v.pos.y >>> FRAC) - cpos[1];
        z = longint'(v.pos.z >>> FRAC) - cpos[2];
        t = cs[2] * x + sn[2] * y;
        y = cs[2] * y - sn[2] * x;
        x = t;
        t = cs[1] * x - sn[1] * z;
        z = sn[1] * x + cs[1] * z;
        x = t;
        t = cs[0] * y + sn[0] * z;
        z = cs[0] * z - sn[0] * y;
        y = t;
        culled   = (z < `GEOM_NEAR);
        sv.depth = q16_16_t'(z <<< FRAC);
        sv.color = v.color;
        if (culled) begin
            sv.sx = '0;
            sv.sy = '0;
        end else begin
            sv.sx = q16_16_t'((x * `GEOM_FOCAL * (1 << FRAC)) / z);  // Truncates toward zero
            sv.sy = q16_16_t'((y * `GEOM_FOCAL * (1 << FRAC)) / z);
        end
        return sv;
    endfunction

    task automatic note_timeout(input string what);
        $display("Timeout at %0d ns: %s", $time, what);
        aborted = 1'b1;
    endtask

    task automatic set_pose(input int px, input int py, input int pz,
                            input int sin_x, input int sin_y, input int sin_z,
                            input int cos_x, input int cos_y, input int cos_z);
        cpos[0] = px;
        cpos[1] = py;
        cpos[2] = pz;
        sn[0] = sin_x;
        sn[1] = sin_y;
        sn[2] = sin_z;
        cs[0] = cos_x;
        cs[1] = cos_y;
        cs[2] = cos_z;
        transform.pos.x     = to_q(px);
        transform.pos.y     = to_q(py);
        transform.pos.z     = to_q(pz);
        transform.rot_sin.x = to_q(sin_x);
        transform.rot_sin.y = to_q(sin_y);
        transform.rot_sin.z = to_q(sin_z);
        transform.rot_cos.x = to_q(cos_x);
        transform.rot_cos.y = to_q(cos_y);
        transform.rot_cos.z = to_q(cos_z);
    endtask

    // Starts and ends just after a falling edge
    task automatic send_triangle(input triangle_t t);
        int waited;
        waited = 0;
        in_triangle = t;
        in_valid    = 1'b1;
        while (!in_ready && !aborted) begin
            @(negedge clk);
            waited++;
            if (waited > LIMIT)
                note_timeout("in_ready never rose to take a triangle");
        end
        @(negedge clk);    // Transfer happened on the rising edge before this
        in_valid = 1'b0;
    endtask

    task automatic send_checked(input triangle_t t);
        screen_triangle_t s;
        logic c0;
        logic c1;
        logic c2;
        s.s0 = expect_vertex(t.v0, c0);
        s.s1 = expect_vertex(t.v1, c1);
        s.s2 = expect_vertex(t.v2, c2);
        if (!(c0 || c1 || c2))
            exp_q.push_back(s);
        send_triangle(t);
    endtask

    task automatic wait_drained(input string what);
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && !aborted) begin
            @(negedge clk);
            waited++;
            if (waited > LIMIT)
                note_timeout(what);
        end
    endtask

    task automatic end_test(input string name);
        if (aborted || error_count != mark) begin
            fail_tests++;
            $display("Test %s: failed", name);
        end else begin
            pass_tests++;
            $display("Test %s: ok", name);
        end
        mark = error_count;
    endtask

    // Every output transfer must match the oldest expected triangle
    always @(posedge clk) begin
        if (!rst && out_valid && out_ready) begin
            assert (exp_q.size() != 0)
            else begin
                $display("Output triangle at %0d ns while none was expected", $time);
                error_count++;
            end
            if (exp_q.size() != 0) begin
                head = exp_q.pop_front();
                assert (out_triangle == head)
                else begin
                    $display("ERROR at %0d ns: screen triangle %h, expected %h",
                             $time, out_triangle, head);
                    error_count++;
                end
            end
        end
    end

    task automatic test_reset_state();
        repeat (20) begin
            @(negedge clk);
            assert (!out_valid)
            else begin
                $display("ERROR at %0d ns: out_valid high with no input", $time);
                error_count++;
            end
            assert (cull_count == 16'd0)
            else begin
                $display("ERROR at %0d ns: cull_count is %0d after reset", $time, cull_count);
                error_count++;
            end
        end
    endtask

    task automatic test_translation();
        set_pose(rand_range(-16, 16), rand_range(-16, 16), rand_range(-32, 0), 0, 0, 0, 1, 1, 1);
        repeat (3) send_checked(random_triangle());
        wait_drained("translated triangle never came out");
    endtask

    task automatic test_yaw();
        set_pose(rand_range(-16, 16), rand_range(-16, 16), rand_range(-32, 0), 0, 0, 1, 1, 1, 0);
        repeat (3) send_checked(random_triangle());
        wait_drained("yawed triangle never came out");
    endtask

    task automatic test_near_plane();
        logic [15:0] cull_before;
        triangle_t   t;
        set_pose(0, 0, 0, 0, 0, 0, 1, 1, 1);
        cull_before = cull_count;
        t = random_triangle();
        t.v1.pos.z = to_q(0);           // One vertex on the camera plane
        send_checked(t);
        send_checked(random_triangle());
        wait_drained("triangle after the rejected one never came out");
        assert (cull_count == cull_before + 16'd1)
        else begin
            $display("ERROR at %0d ns: cull_count is %0d, expected %0d",
                     $time, cull_count, cull_before + 16'd1);
            error_count++;
        end
    endtask

    task automatic test_back_pressure();
        int low_run;
        int waited;
        set_pose(rand_range(-16, 16), rand_range(-16, 16), rand_range(-32, 0), 0, 0, 0, 1, 1, 1);
        out_ready = 1'b0;
        low_run   = 0;
        waited    = 0;
        fork
            begin
                repeat (10) send_checked(random_triangle());
            end
            begin
                // Release only once the whole chain has backed up
                while (low_run < STALL && !aborted) begin
                    @(negedge clk);
                    low_run = in_ready ? 0 : low_run + 1;
                    waited++;
                    if (waited > LIMIT)
                        note_timeout("in_ready never stayed low under back-pressure");
                end
                out_ready = 1'b1;
            end
        join
        wait_drained("stalled triangles never all came out");
    endtask

    initial begin
        seed        = 32'h9c77511f;
        error_count = 0;
        mark        = 0;
        pass_tests  = 0;
        fail_tests  = 0;
        aborted     = 1'b0;
        rst         = 1'b1;
        in_valid    = 1'b0;
        in_triangle = '0;
        transform   = '0;
        out_ready   = 1'b0;
        repeat (16) @(negedge clk);
        rst = 1'b0;

        test_reset_state();
        end_test("reset state");
        out_ready = 1'b1;
        if (!aborted) begin
            test_translation();
            end_test("translation only");
        end
        if (!aborted) begin
            test_yaw();
            end_test("yaw of 90 degrees");
        end
        if (!aborted) begin
            test_near_plane();
            end_test("near-plane rejection");
        end
        if (!aborted) begin
            test_back_pressure();
            end_test("back-pressure and order");
        end

        $display("Tests passed: %0d, failed: %0d, bound assertion failures: %0d",
                 pass_tests, fail_tests, dut_i.props_i.fail_count);
        if (aborted || fail_tests != 0 || dut_i.props_i.fail_count != 0) begin
            $display("*** FAILED ***");
        end else begin
            $display("*** PASSED ***");
        end
        $finish;
    end

endmodule

/* test/geometry_front_props.sv */
`timescale 1ns/1ps

// Protocol checks on the geometry front end, bound into geometry_front
module geometry_front_props
    import geom_pkg::*;
(
    input logic             clk,
    input logic             rst,
    input logic             in_valid,
    input logic             in_ready,
    input logic             busy,
    input screen_triangle_t out_triangle,
    input logic             out_valid,
    input logic             out_ready,
    input logic [15:0]      cull_count
);

    int unsigned fail_count;    // Read by the testbench at the end of the run

    initial fail_count = 0;

    // Nothing pending on the first cycle out of reset
    quiet_after_reset: assert property (
        @(posedge clk) $fell(rst) |-> (!out_valid && !busy && cull_count == 16'd0)
    ) else begin
        fail_count++;
        $error("out_valid, busy or cull_count active on the first cycle after reset");
    end

    hold_while_stalled: assert property (
        @(posedge clk) disable iff (rst)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_triangle))
    ) else begin
        fail_count++;
        $error("output triangle changed while stalled");
    end

    cull_steps_by_one: assert property (
        @(posedge clk) disable iff (rst)
        !$stable(cull_count) |-> (cull_count == $past(cull_count) + 16'd1)
    ) else begin
        fail_count++;
        $error("cull_count moved by more than one");
    end

    // Transformer starts loading right after it takes a triangle
    busy_after_accept: assert property (
        @(posedge clk) disable iff (rst)
        (in_valid && in_ready) |=> busy
    ) else begin
        fail_count++;
        $error("busy low on the cycle after an accepted triangle");
    end

endmodule

bind geometry_front geometry_front_props props_i (
    .clk          (clk),
    .rst          (rst),
    .in_valid     (in_valid),
    .in_ready     (in_ready),
    .busy         (busy),
    .out_triangle (out_triangle),
    .out_valid    (out_valid),
    .out_ready    (out_ready),
    .cull_count   (cull_count)
);

/* source/geometry_front.sv */
`timescale 1ns/1ps
`include "geom_macros.svh"

// Transformer, camera-space buffer, projector, screen-space buffer
module geometry_front
    import geom_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  transform_t       transform,
    input  triangle_t        in_triangle,
    input  logic             in_valid,
    output logic             in_ready,
    output logic             busy,
    output screen_triangle_t out_triangle,
    output logic             out_valid,
    input  logic             out_ready,
    output logic [15:0]      cull_count
);

    triangle_t        cam_tri;
    logic             cam_valid;
    logic             cam_room;     // Transformer pulses out_valid, so it waits for room
    triangle_t        proj_tri;
    logic             proj_valid;
    logic             proj_ready;
    screen_triangle_t scr_tri;
    logic             scr_valid;
    logic             scr_ready;

    world_camera_transformer u_transformer (
        .clk          (clk),
        .rst          (rst),
        .transform    (transform),
        .triangle     (in_triangle),
        .in_valid     (in_valid),
        .ready        (in_ready),
        .out_triangle (cam_tri),
        .out_valid    (cam_valid),
        .out_ready    (cam_room),
        .busy         (busy)
    );

    triangle_fifo #(
        .payload_t (triangle_t),
        .DEPTH     (`GEOM_FIFO_DEPTH)
    ) cam_fifo (
        .clk       (clk),
        .rst       (rst),
        .in_data   (cam_tri),
        .in_valid  (cam_valid),
        .in_ready  (cam_room),
        .out_data  (proj_tri),
        .out_valid (proj_valid),
        .out_ready (proj_ready)
    );

    perspective_projector u_projector (
        .clk          (clk),
        .rst          (rst),
        .in_triangle  (proj_tri),
        .in_valid     (proj_valid),
        .in_ready     (proj_ready),
        .out_triangle (scr_tri),
        .out_valid    (scr_valid),
        .out_ready    (scr_ready),
        .cull_count   (cull_count)
    );

    triangle_fifo #(
        .payload_t (screen_triangle_t),
        .DEPTH     (`GEOM_FIFO_DEPTH)
    ) screen_fifo (
        .clk       (clk),
        .rst       (rst),
        .in_data   (scr_tri),
        .in_valid  (scr_valid),
        .in_ready  (scr_ready),
        .out_data  (out_triangle),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

endmodule

/* source/perspective_projector.sv */
`timescale 1ns/1ps
`include "geom_macros.svh"

// Near-plane rejection and perspective divide, one quotient bit per cycle
module perspective_projector
    import geom_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  triangle_t        in_triangle,
    input  logic             in_valid,
    output logic             in_ready,
    output screen_triangle_t out_triangle,
    output logic             out_valid,
    input  logic             out_ready,
    output logic [15:0]      cull_count
);

    localparam int      NUM_W  = 64;
    localparam int      CNT_W  = $clog2(NUM_W);
    localparam q16_16_t NEAR_Q = q16_16_t'(`GEOM_NEAR * (1 << `GEOM_FRAC_BITS));

    typedef enum logic [2:0] {S_IDLE, S_CHECK, S_SETUP, S_DIV, S_OUT} state_t;

    state_t             state;
    triangle_t          tri_q;
    logic [2:0]         div_idx;    // Coordinate being divided, v0.x through v2.y
    logic [CNT_W-1:0]   bit_cnt;
    logic [NUM_W-1:0]   num;
    logic [NUM_W-1:0]   quo;
    logic [31:0]        den;
    logic [31:0]        rem;
    logic               neg;

    q16_16_t            sel_coord;
    q16_16_t            sel_z;
    logic [31:0]        abs_coord;
    logic               near_fail;
    logic [32:0]        rem_shift;
    logic [32:0]        rem_diff;
    logic               rem_ge;
    logic [NUM_W-1:0]   quo_next;
    q16_16_t            result;
    logic               last_bit;

    always_comb begin
        case (div_idx)
            3'd0: begin sel_coord = tri_q.v0.pos.x; sel_z = tri_q.v0.pos.z; end
            3'd1: begin sel_coord = tri_q.v0.pos.y; sel_z = tri_q.v0.pos.z; end
            3'd2: begin sel_coord = tri_q.v1.pos.x; sel_z = tri_q.v1.pos.z; end
            3'd3: begin sel_coord = tri_q.v1.pos.y; sel_z = tri_q.v1.pos.z; end
            3'd4: begin sel_coord = tri_q.v2.pos.x; sel_z = tri_q.v2.pos.z; end
            default: begin sel_coord = tri_q.v2.pos.y; sel_z = tri_q.v2.pos.z; end
        endcase
        abs_coord = sel_coord[31] ? -sel_coord : sel_coord;

        near_fail = (tri_q.v0.pos.z < NEAR_Q) || (tri_q.v1.pos.z < NEAR_Q) ||
                    (tri_q.v2.pos.z < NEAR_Q);

        // Restoring step
        rem_shift = {rem, num[NUM_W-1]};
        rem_diff  = rem_shift - {1'b0, den};
        rem_ge    = (rem_shift >= {1'b0, den});
        quo_next  = {quo[NUM_W-2:0], rem_ge};
        result    = neg ? -q16_16_t'(quo_next[31:0]) : q16_16_t'(quo_next[31:0]);
        last_bit  = (bit_cnt == CNT_W'(NUM_W - 1));
    end

    assign in_ready  = (state == S_IDLE);
    assign out_valid = (state == S_OUT);

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= S_IDLE;
            div_idx    <= 3'd0;
            bit_cnt    <= '0;
            cull_count <= 16'd0;
        end else begin
            case (state)
                S_IDLE:
                    if (in_valid)
                        state <= S_CHECK;
                S_CHECK:
                    if (near_fail) begin
                        cull_count <= cull_count + 16'd1;   // Dropped whole
                        state      <= S_IDLE;
                    end else begin
                        div_idx <= 3'd0;
                        state   <= S_SETUP;
                    end
                S_SETUP: begin
                    bit_cnt <= '0;
                    state   <= S_DIV;
                end
                S_DIV:
                    if (last_bit) begin
                        if (div_idx == 3'd5) begin
                            state <= S_OUT;
                        end else begin
                            div_idx <= div_idx + 3'd1;
                            state   <= S_SETUP;
                        end
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                S_OUT:
                    if (out_ready)
                        state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && in_valid)
            tri_q <= in_triangle;

        if (state == S_CHECK) begin
            out_triangle.s0.depth <= tri_q.v0.pos.z;
            out_triangle.s0.color <= tri_q.v0.color;
            out_triangle.s1.depth <= tri_q.v1.pos.z;
            out_triangle.s1.color <= tri_q.v1.color;
            out_triangle.s2.depth <= tri_q.v2.pos.z;
            out_triangle.s2.color <= tri_q.v2.color;
        end

        // Numerator is |coord| * focal, scaled up so the quotient stays Q16.16
        if (state == S_SETUP) begin
            num <= ({32'd0, abs_coord} * NUM_W'(`GEOM_FOCAL)) << `GEOM_FRAC_BITS;
            den <= sel_z;           // Positive after the near-plane test
            rem <= 32'd0;
            quo <= '0;
            neg <= sel_coord[31];
        end

        if (state == S_DIV) begin
            rem <= rem_ge ? rem_diff[31:0] : rem_shift[31:0];
            num <= num << 1;
            quo <= quo_next;
            if (last_bit) begin
                case (div_idx)
                    3'd0:    out_triangle.s0.sx <= result;
                    3'd1:    out_triangle.s0.sy <= result;
                    3'd2:    out_triangle.s1.sx <= result;
                    3'd3:    out_triangle.s1.sy <= result;
                    3'd4:    out_triangle.s2.sx <= result;
                    default: out_triangle.s2.sy <= result;
                endcase
            end
        end
    end

endmodule

/* source/world_camera_transformer.sv */
`timescale 1ns/1ps
`include "geom_macros.svh"

// Moves a world-space triangle into camera space, p_cam = R^T * (p_world - C)
module world_camera_transformer
    import geom_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  transform_t transform,
    input  triangle_t  triangle,
    input  logic       in_valid,
    output logic       ready,
    output triangle_t  out_triangle,
    output logic       out_valid,
    input  logic       out_ready,
    output logic       busy
);

    // Q16.16 multiply through a 64-bit product
    function automatic q16_16_t q_mul(input q16_16_t a, input q16_16_t b);
        logic signed [63:0] prod;
        prod = a * b;
        return q16_16_t'(prod >>> `GEOM_FRAC_BITS);
    endfunction

    // Three products summed wide, one shift at the end
    function automatic q16_16_t dot3(input q16_16_t a0, input q16_16_t a1, input q16_16_t a2,
                                     input q16_16_t b0, input q16_16_t b1, input q16_16_t b2);
        logic signed [65:0] acc;
        acc = a0 * b0 + a1 * b1 + a2 * b2;
        return q16_16_t'(acc >>> `GEOM_FRAC_BITS);
    endfunction

    q16_16_t r11, r12, r13;
    q16_16_t r21, r22, r23;
    q16_16_t r31, r32, r33;
    q16_16_t cz_sy, sz_sy;

    triangle_t  tri_q;          // Triangle held while its vertices load
    vertex_t    load_vtx;
    vertex_t    trans_v;
    vertex_t    rot_v;
    logic       accept;
    logic       loading;
    logic [1:0] load_cnt;
    logic       trans_valid;
    logic       rot_valid;
    logic [1:0] col_cnt;        // Vertices collected so far
    logic       done;           // All three collected, waiting for room

    // ZYX rotation matrix
    always_comb begin
        cz_sy = q_mul(transform.rot_cos.z, transform.rot_sin.y);
        sz_sy = q_mul(transform.rot_sin.z, transform.rot_sin.y);
        r11 = q_mul(transform.rot_cos.z, transform.rot_cos.y);
        r12 = q_mul(cz_sy, transform.rot_sin.x) - q_mul(transform.rot_sin.z, transform.rot_cos.x);
        r13 = q_mul(cz_sy, transform.rot_cos.x) + q_mul(transform.rot_sin.z, transform.rot_sin.x);
        r21 = q_mul(transform.rot_sin.z, transform.rot_cos.y);
        r22 = q_mul(sz_sy, transform.rot_sin.x) + q_mul(transform.rot_cos.z, transform.rot_cos.x);
        r23 = q_mul(sz_sy, transform.rot_cos.x) - q_mul(transform.rot_cos.z, transform.rot_sin.x);
        r31 = -transform.rot_sin.y;
        r32 = q_mul(transform.rot_cos.y, transform.rot_sin.x);
        r33 = q_mul(transform.rot_cos.y, transform.rot_cos.x);
    end

    always_comb begin
        case (load_cnt)
            2'd0:    load_vtx = tri_q.v0;
            2'd1:    load_vtx = tri_q.v1;
            default: load_vtx = tri_q.v2;
        endcase
    end

    assign busy   = loading | trans_valid | rot_valid | (col_cnt != 2'd0) | done;
    assign ready  = out_ready & ~busy;  // One triangle in flight at a time
    assign accept = in_valid & ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            loading     <= 1'b0;
            load_cnt    <= 2'd0;
            trans_valid <= 1'b0;
            rot_valid   <= 1'b0;
            col_cnt     <= 2'd0;
            done        <= 1'b0;
            out_valid   <= 1'b0;
        end else begin
            out_valid   <= 1'b0;      // Single-cycle pulse
            trans_valid <= loading;
            rot_valid   <= trans_valid;

            if (accept) begin
                loading  <= 1'b1;
                load_cnt <= 2'd0;
            end else if (loading) begin
                if (load_cnt == 2'd2) begin
                    loading  <= 1'b0;
                    load_cnt <= 2'd0;
                end else begin
                    load_cnt <= load_cnt + 2'd1;
                end
            end

            if (rot_valid) begin
                if (col_cnt == 2'd2) begin
                    col_cnt <= 2'd0;
                    done    <= 1'b1;
                end else begin
                    col_cnt <= col_cnt + 2'd1;
                end
            end

            if (done && out_ready) begin
                done      <= 1'b0;
                out_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept)
            tri_q <= triangle;

        // Translate stage
        if (loading) begin
            trans_v.pos.x <= load_vtx.pos.x - transform.pos.x;
            trans_v.pos.y <= load_vtx.pos.y - transform.pos.y;
            trans_v.pos.z <= load_vtx.pos.z - transform.pos.z;
            trans_v.color <= load_vtx.color;
        end

        // Rotate stage, each row of R^T is a column of R
        if (trans_valid) begin
            rot_v.pos.x <= dot3(r11, r21, r31, trans_v.pos.x, trans_v.pos.y, trans_v.pos.z);
            rot_v.pos.y <= dot3(r12, r22, r32, trans_v.pos.x, trans_v.pos.y, trans_v.pos.z);
            rot_v.pos.z <= dot3(r13, r23, r33, trans_v.pos.x, trans_v.pos.y, trans_v.pos.z);
            rot_v.color <= trans_v.color;
        end

        // Collect stage
        if (rot_valid) begin
            case (col_cnt)
                2'd0:    out_triangle.v0 <= rot_v;
                2'd1:    out_triangle.v1 <= rot_v;
                default: out_triangle.v2 <= rot_v;
            endcase
        end
    end

endmodule

/* source/triangle_fifo.sv */
`timescale 1ns/1ps

// Circular buffer with valid/ready on both sides
module triangle_fifo #(
    parameter type payload_t = logic [31:0],
    parameter int  DEPTH     = 4
) (
    input  logic     clk,
    input  logic     rst,
    input  payload_t in_data,
    input  logic     in_valid,
    output logic     in_ready,
    output payload_t out_data,
    output logic     out_valid,
    input  logic     out_ready
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t           mem [DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;
    logic               wr_en;
    logic               rd_en;

    assign in_ready  = (count != CNT_W'(DEPTH));
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];   // Head of the queue
    assign wr_en     = in_valid & in_ready;
    assign rd_en     = out_valid & out_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en)
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (rd_en)
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (wr_en && !rd_en)
                count <= count + 1'b1;
            else if (rd_en && !wr_en)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en)
            mem[wr_ptr] <= in_data;
    end

endmodule

/* source/geom_pkg.sv */
package geom_pkg;

    // Signed Q16.16 fixed point
    typedef logic signed [31:0] q16_16_t;

    typedef logic [23:0] color_t;  // 8 bits per channel, RGB

    typedef struct packed {
        q16_16_t x;
        q16_16_t y;
        q16_16_t z;
    } vec3_t;

    typedef struct packed {
        vec3_t  pos;
        color_t color;
    } vertex_t;

    typedef struct packed {
        vertex_t v0;
        vertex_t v1;
        vertex_t v2;
    } triangle_t;

    // Camera pose, rotation given as per-axis sine and cosine
    typedef struct packed {
        vec3_t pos;
        vec3_t rot_sin;
        vec3_t rot_cos;
    } transform_t;

    typedef struct packed {
        q16_16_t sx;
        q16_16_t sy;
        q16_16_t depth;    // Camera-space z
        color_t  color;
    } screen_vertex_t;

    typedef struct packed {
        screen_vertex_t s0;
        screen_vertex_t s1;
        screen_vertex_t s2;
    } screen_triangle_t;

endpackage

/* include/geom_macros.svh */
`ifndef GEOM_MACROS_SVH
`define GEOM_MACROS_SVH

// Fixed-point format is Q16.16
`define GEOM_FRAC_BITS 16

`define GEOM_FOCAL 256      // Focal length in whole units
`define GEOM_NEAR 1         // Near plane z in whole units
`define GEOM_FIFO_DEPTH 4   // Triangles per buffer

`endif
